/* all.f */
+incdir+design
+incdir+bench
design/dsp_pkg.sv
design/dsp_cfg_regs.sv
design/code_history.sv
design/lane_ffe.sv
design/bit_slicer.sv
design/mlsd_checker.sv
design/dsp_backend_top.sv
bench/dsp_backend_tb.sv

/* bench/dsp_backend_model.svh */
`ifndef DSP_BACKEND_MODEL_SVH
`define DSP_BACKEND_MODEL_SVH

localparam int EST_HI = (1 << (`DSP_EST_W - 1)) - 1;

// configuration that the DUT should hold after the writes so far.
int weight[`DSP_LANES][`DSP_FFE_TAPS];
int chan_est[`DSP_LANES][`DSP_EST_TAPS];
int ffe_shift[`DSP_LANES];
int mlsd_shift[`DSP_LANES];
int thr[`DSP_LANES];

// hist holds lanes 2 and 3 of the previous word, oldest first.
int   hist[2];
logic last_chk;
logic first_word;

function automatic void clear_model();
	weight     = '{default: 0};
	chan_est   = '{default: 0};
	ffe_shift  = '{default: 0};
	mlsd_shift = '{default: 0};
	thr        = '{default: 0};
	hist       = '{default: 0};
	last_chk   = 1'b0;
	first_word = 1'b1;
endfunction

// equalizes one word and moves the sample history on.
function automatic est_word_s equalize(code_word_s c);
	int        smp[`DSP_LANES + 2];
	int        acc;
	est_word_s e;
	smp[0] = hist[0];
	smp[1] = hist[1];
	for (int k = 0; k < `DSP_LANES; k++) begin
		smp[k + 2] = $signed(c.code[k]);
	end
	for (int k = 0; k < `DSP_LANES; k++) begin
		acc = 0;
		for (int t = 0; t < `DSP_FFE_TAPS; t++) begin
			acc += weight[k][t] * smp[k + 2 - t];
		end
		acc = acc >>> ffe_shift[k];
		acc = (acc > EST_HI) ? EST_HI : (acc < -EST_HI - 1) ? -EST_HI - 1 : acc;
		e.est[k] = acc[`DSP_EST_W-1:0];
	end
	hist[0] = smp[`DSP_LANES];
	hist[1] = smp[`DSP_LANES + 1];
	return e;
endfunction

function automatic bit_word_s slice(est_word_s e);
	bit_word_s b;
	for (int k = 0; k < `DSP_LANES; k++) begin
		b.b[k] = $signed(e.est[k]) >= thr[k];
	end
	return b;
endfunction

// a bit of 1 is sent as +1 and a bit of 0 as -1.
function automatic int symbol_of(logic b);
	return b ? 1 : -1;
endfunction

function automatic bit_word_s decide(code_word_s c, bit_word_s sl);
	bit_word_s r;
	logic      prev;
	int        exp_one;
	int        exp_zero;
	int        d_one;
	int        d_zero;
	prev = last_chk;
	for (int k = 0; k < `DSP_LANES; k++) begin
		// cursor times the candidate symbol plus post-cursor times the previous symbol.
		exp_one  = chan_est[k][0] * symbol_of(1'b1) + chan_est[k][1] * symbol_of(prev);
		exp_zero = chan_est[k][0] * symbol_of(1'b0) + chan_est[k][1] * symbol_of(prev);
		d_one    = $signed(c.code[k]) - (exp_one >>> mlsd_shift[k]);
		d_zero   = $signed(c.code[k]) - (exp_zero >>> mlsd_shift[k]);
		d_one    = (d_one < 0) ? -d_one : d_one;
		d_zero   = (d_zero < 0) ? -d_zero : d_zero;
		r.b[k] = d_one <= d_zero;
		if (k == 0 && first_word) begin
			r.b[k] = sl.b[k];
		end
		prev = r.b[k];
	end
	last_chk   = r.b[`DSP_LANES-1];
	first_word = 1'b0;
	return r;
endfunction

task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
	if (got !== exp) begin
		errors++;
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
	end
endtask

`endif

/* bench/dsp_backend_tb.sv */
`timescale 1ns/1ns

`include "dsp_defines.svh"

module dsp_backend_tb import dsp_pkg::*; ();

	localparam int IDLE_LIMIT = 50;

	logic       clk;
	logic       rst_n_i;
	logic       cfg_we_i;
	cfg_kind_e  cfg_kind_i;
	cfg_word_u  cfg_word_i;
	logic       code_vld_i;
	code_word_s code_i;
	logic       est_vld_o;
	est_word_s  est_o;
	logic       chk_vld_o;
	bit_word_s  chk_o;

	int        errors;
	int        checked;
	int        cyc;
	est_word_s exp_est_q[$];
	bit_word_s exp_chk_q[$];
	int        est_due_q[$];
	int        chk_due_q[$];

`include "dsp_backend_model.svh"

	dsp_backend_top dsp_backend_top_i (.*);

	always #50 clk = ~clk;

	task automatic drive_idle();
		@(posedge clk);
		code_vld_i <= 1'b0;
		cfg_we_i   <= 1'b0;
	endtask

	task automatic drive_cfg(cfg_kind_e kind, cfg_word_u word);
		@(posedge clk);
		code_vld_i <= 1'b0;
		cfg_we_i   <= 1'b1;
		cfg_kind_i <= kind;
		cfg_word_i <= word;
	endtask

	task automatic write_coef(cfg_kind_e kind, int lane, int tap,
			logic signed [`DSP_COEF_W-1:0] coef);
		cfg_word_u w;
		w = '0;
		w.coef.lane = lane[1:0];
		w.coef.tap  = tap[1:0];
		w.coef.coef = coef;
		drive_cfg(kind, w);
		if (kind == CFG_FFE_WEIGHT) begin
			weight[lane][tap] = coef;
		end else begin
			chan_est[lane][tap] = coef;
		end
	endtask

	task automatic write_lane(int lane, int fsh, int msh, logic signed [`DSP_THR_W-1:0] t);
		cfg_word_u w;
		w.lane.lane       = lane[1:0];
		w.lane.ffe_shift  = fsh[`DSP_SHIFT_W-1:0];
		w.lane.mlsd_shift = msh[`DSP_SHIFT_W-1:0];
		w.lane.thr        = t;
		drive_cfg(CFG_LANE, w);
		ffe_shift[lane]  = fsh;
		mlsd_shift[lane] = msh;
		thr[lane]        = t;
	endtask

	// the expected results are computed when the word goes out.
	task automatic drive_code(code_word_s c);
		est_word_s e;
		e = equalize(c);
		exp_est_q.push_back(e);
		exp_chk_q.push_back(decide(c, slice(e)));
		@(posedge clk);
		code_vld_i <= 1'b1;
		cfg_we_i   <= 1'b0;
		code_i     <= c;
		est_due_q.push_back(cyc + 3);
		chk_due_q.push_back(cyc + 5);
	endtask

	// back to back words half of the time, otherwise a gap of up to three cycles.
	task automatic run_words(int count);
		for (int i = 0; i < count; i++) begin
			drive_code(code_word_s'($urandom));
			if ($urandom % 2) begin
				repeat ($urandom % 3 + 1) drive_idle();
			end
		end
	endtask

	task automatic random_weights(int bits);
		logic signed [`DSP_COEF_W-1:0] v;
		for (int k = 0; k < `DSP_LANES; k++) begin
			for (int t = 0; t < `DSP_FFE_TAPS; t++) begin
				v = $urandom;
				write_coef(CFG_FFE_WEIGHT, k, t, v >>> (`DSP_COEF_W - bits));
			end
		end
	endtask

	task automatic random_lanes();
		for (int k = 0; k < `DSP_LANES; k++) begin
			write_lane(k, $urandom % 8, $urandom % 8, $urandom);
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while ((exp_est_q.size() != 0 || exp_chk_q.size() != 0) && n < IDLE_LIMIT) begin
			drive_idle();
			n++;
		end
		if (exp_est_q.size() != 0 || exp_chk_q.size() != 0) begin
			$display("timeout: %0d equalized and %0d checked words never came out",
				exp_est_q.size(), exp_chk_q.size());
			$display("run stopped: %0d words checked, %0d errors", checked, errors + 1);
			$display("TESTBENCH FAILED");
			$finish;
		end
	endtask

	task automatic apply_reset(int cycles);
		@(posedge clk);
		rst_n_i    <= 1'b0;
		code_vld_i <= 1'b0;
		cfg_we_i   <= 1'b0;
		repeat (cycles) @(posedge clk);
		rst_n_i <= 1'b1;
		clear_model();
	endtask

	task automatic check_quiet(int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_value("est_vld_o", est_vld_o, 1'b0);
			check_value("chk_vld_o", chk_vld_o, 1'b0);
		end
	endtask

	// outputs are sampled on the falling edge, away from the registers.
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (rst_n_i && est_vld_o) begin
			if (exp_est_q.size() == 0) begin
				errors++;
				$display("est_vld_o went high with no word outstanding");
			end else begin
				check_value("est_o", est_o, exp_est_q.pop_front());
				check_value("est_vld_o cycle", cyc, est_due_q.pop_front());
			end
		end
		if (rst_n_i && chk_vld_o) begin
			if (exp_chk_q.size() == 0) begin
				errors++;
				$display("chk_vld_o went high with no word outstanding");
			end else begin
				checked++;
				check_value("chk_o", chk_o, exp_chk_q.pop_front());
				check_value("chk_vld_o cycle", cyc, chk_due_q.pop_front());
			end
		end
	end

	initial begin
		clk        = 1'b0;
		rst_n_i    = 1'b0;
		cfg_we_i   = 1'b0;
		cfg_kind_i = CFG_FFE_WEIGHT;
		cfg_word_i = '0;
		code_vld_i = 1'b0;
		code_i     = '0;
		errors     = 0;
		checked    = 0;
		cyc        = 0;
		void'($urandom(33));
		apply_reset(5);

		// tap 0 alone passes each code straight through.
		for (int k = 0; k < `DSP_LANES; k++) begin
			write_coef(CFG_FFE_WEIGHT, k, 0, 1);
		end
		run_words(8);
		wait_idle();

		// full range weights saturate at both ends, small ones mostly stay linear.
		random_weights(`DSP_COEF_W);
		run_words(150);
		random_weights(5);
		run_words(150);
		wait_idle();

		// every reset makes lane 0 of the first word follow the slicer.
		repeat (4) begin
			apply_reset(3);
			random_weights(7);
			random_lanes();
			run_words(6);
			wait_idle();
		end

		for (int k = 0; k < `DSP_LANES; k++) begin
			write_coef(CFG_CHAN_EST, k, 0, $urandom);
			write_coef(CFG_CHAN_EST, k, 1, $urandom);
		end
		random_lanes();
		run_words(100);
		wait_idle();
		// a zero cursor makes both candidates equally far away.
		write_coef(CFG_CHAN_EST, 1, 0, 0);
		run_words(100);
		wait_idle();

		for (int i = 0; i < 20; i++) begin
			drive_code(code_word_s'($urandom));
			write_coef(CFG_FFE_WEIGHT, $urandom % `DSP_LANES, $urandom % 3, $urandom);
		end
		wait_idle();
		apply_reset(2);
		check_quiet(6);
		random_weights(6);
		run_words(20);
		wait_idle();

		$display("run complete: %0d words checked, %0d errors", checked, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* design/bit_slicer.sv */
`timescale 1ns/1ns

`include "dsp_defines.svh"

module bit_slicer import dsp_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      est_vld_i,
	input  est_word_s est_i,
	input  mlsd_cfg_s mlsd_cfg_i,
	output logic      bit_vld_o,
	output bit_word_s bits_o
);

	bit_word_s bits_d;

	always_comb begin
		for (int k = 0; k < `DSP_LANES; k++) begin
			bits_d.b[k] = $signed(est_i.est[k]) >= $signed(mlsd_cfg_i.thr[k]);
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bit_vld_o <= 1'b0;
		end else begin
			bit_vld_o <= est_vld_i;
		end
	end

	always_ff @(posedge clk) begin
		if (est_vld_i) begin
			bits_o <= bits_d;
		end
	end

endmodule

/* design/code_history.sv */
`timescale 1ns/1ns

`include "dsp_defines.svh"

module code_history import dsp_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       code_vld_i,
	input  code_word_s code_i,
	output logic       win_vld_o,
	output win_word_s  win_o,
	output code_word_s code_q_o
);

	localparam int PAST = `DSP_FFE_TAPS - 1;

	code_word_s                       code_q;
	logic [PAST-1:0][`DSP_CODE_W-1:0] past_q;
	logic                             vld_q;

	// the history starts from zero so samples before reset count as zero.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			code_q <= '0;
			past_q <= '0;
			vld_q  <= 1'b0;
		end else begin
			vld_q <= code_vld_i;
			if (code_vld_i) begin
				code_q <= code_i;
				past_q <= code_q.code[`DSP_LANES-1 -: PAST];
			end
		end
	end

	assign win_vld_o = vld_q;
	assign win_o     = {code_q.code, past_q};
	assign code_q_o  = code_q;

endmodule

/* design/dsp_backend_top.sv */
`timescale 1ns/1ns

`include "dsp_defines.svh"

module dsp_backend_top import dsp_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       cfg_we_i,
	input  cfg_kind_e  cfg_kind_i,
	input  cfg_word_u  cfg_word_i,
	input  logic       code_vld_i,
	input  code_word_s code_i,
	output logic       est_vld_o,
	output est_word_s  est_o,
	output logic       chk_vld_o,
	output bit_word_s  chk_o
);

	ffe_cfg_s   ffe_cfg;
	mlsd_cfg_s  mlsd_cfg;
	logic       win_vld;
	win_word_s  win;
	code_word_s code_q;
	logic       bit_vld;
	bit_word_s  bits;

	dsp_cfg_regs dsp_cfg_regs_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.cfg_we_i   (cfg_we_i),
		.cfg_kind_i (cfg_kind_i),
		.cfg_word_i (cfg_word_i),
		.ffe_cfg_o  (ffe_cfg),
		.mlsd_cfg_o (mlsd_cfg)
	);

	code_history code_history_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.code_vld_i (code_vld_i),
		.code_i     (code_i),
		.win_vld_o  (win_vld),
		.win_o      (win),
		.code_q_o   (code_q)
	);

	lane_ffe lane_ffe_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.win_vld_i  (win_vld),
		.win_i      (win),
		.ffe_cfg_i  (ffe_cfg),
		.est_vld_o  (est_vld_o),
		.est_o      (est_o)
	);

	bit_slicer bit_slicer_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.est_vld_i  (est_vld_o),
		.est_i      (est_o),
		.mlsd_cfg_i (mlsd_cfg),
		.bit_vld_o  (bit_vld),
		.bits_o     (bits)
	);

	mlsd_checker mlsd_checker_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.bit_vld_i  (bit_vld),
		.bits_i     (bits),
		.code_q_i   (code_q),
		.mlsd_cfg_i (mlsd_cfg),
		.chk_vld_o  (chk_vld_o),
		.chk_o      (chk_o)
	);

endmodule

/* design/dsp_cfg_regs.sv */
`timescale 1ns/1ns

`include "dsp_defines.svh"

module dsp_cfg_regs import dsp_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      cfg_we_i,
	input  cfg_kind_e cfg_kind_i,
	input  cfg_word_u cfg_word_i,
	output ffe_cfg_s  ffe_cfg_o,
	output mlsd_cfg_s mlsd_cfg_o
);

	ffe_cfg_s  ffe_q;
	mlsd_cfg_s mlsd_q;
	cfg_coef_s wr_coef;
	cfg_lane_s wr_lane;

	// the same write word is read through one of two views, picked by the kind.
	assign wr_coef = cfg_word_i.coef;
	assign wr_lane = cfg_word_i.lane;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ffe_q  <= '0;
			mlsd_q <= '0;
		end else if (cfg_we_i) begin
			case (cfg_kind_i)
				CFG_FFE_WEIGHT: begin
					if (wr_coef.tap < `DSP_FFE_TAPS) begin
						ffe_q.weight[wr_coef.lane][wr_coef.tap] <= wr_coef.coef;
					end
				end
				CFG_CHAN_EST: begin
					if (wr_coef.tap < `DSP_EST_TAPS) begin
						mlsd_q.est[wr_coef.lane][wr_coef.tap[0]] <= wr_coef.coef;
					end
				end
				CFG_LANE: begin
					ffe_q.shift[wr_lane.lane]  <= wr_lane.ffe_shift;
					mlsd_q.shift[wr_lane.lane] <= wr_lane.mlsd_shift;
					mlsd_q.thr[wr_lane.lane]   <= wr_lane.thr;
				end
				default: begin
					ffe_q <= ffe_q;
				end
			endcase
		end
	end

	assign ffe_cfg_o  = ffe_q;
	assign mlsd_cfg_o = mlsd_q;

	// a write with an undefined kind would be dropped silently.
	a_cfg_kind_legal: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		cfg_we_i |-> (cfg_kind_i inside {CFG_FFE_WEIGHT, CFG_CHAN_EST, CFG_LANE})
	);

	// the channel estimate has a cursor and a single post-cursor only.
	a_chan_est_tap: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		(cfg_we_i && cfg_kind_i == CFG_CHAN_EST) |-> (wr_coef.tap < `DSP_EST_TAPS)
	);

endmodule

/* design/dsp_defines.svh */
`ifndef DSP_DEFINES_SVH
`define DSP_DEFINES_SVH

// parallel lanes carried by one incoming word.
`define DSP_LANES     4

// tap 0 is the current sample, taps 1 and 2 reach back in time across lanes.
`define DSP_FFE_TAPS  3

// channel estimate holds the cursor and one post-cursor.
`define DSP_EST_TAPS  2

`define DSP_CODE_W    8
`define DSP_COEF_W    10
`define DSP_EST_W     10
`define DSP_THR_W     8
`define DSP_SHIFT_W   3

`endif

/* design/dsp_pkg.sv */
package dsp_pkg;

`include "dsp_defines.svh"

	typedef enum logic [1:0] {
		CFG_FFE_WEIGHT = 2'd0,
		CFG_CHAN_EST   = 2'd1,
		CFG_LANE       = 2'd2
	} cfg_kind_e;

	// coefficient view, used by FFE weight and channel estimate writes.
	typedef struct packed {
		logic [1:0]                    lane;
		logic [1:0]                    tap;
		logic signed [`DSP_COEF_W-1:0] coef;
		logic [1:0]                    pad;
	} cfg_coef_s;

	// per-lane view, used by shift and threshold writes.
	typedef struct packed {
		logic [1:0]                   lane;
		logic [`DSP_SHIFT_W-1:0]      ffe_shift;
		logic [`DSP_SHIFT_W-1:0]      mlsd_shift;
		logic signed [`DSP_THR_W-1:0] thr;
	} cfg_lane_s;

	typedef union packed {
		cfg_coef_s coef;
		cfg_lane_s lane;
	} cfg_word_u;

	// lane 0 sits in the low bits and is the earliest sample in time.
	typedef struct packed {
		logic [`DSP_LANES-1:0][`DSP_CODE_W-1:0] code;
	} code_word_s;

	// smp[0] and smp[1] are the last two samples of the previous word.
	typedef struct packed {
		logic [`DSP_LANES+`DSP_FFE_TAPS-2:0][`DSP_CODE_W-1:0] smp;
	} win_word_s;

	typedef struct packed {
		logic [`DSP_LANES-1:0][`DSP_EST_W-1:0] est;
	} est_word_s;

	typedef struct packed {
		logic [`DSP_LANES-1:0] b;
	} bit_word_s;

	typedef struct packed {
		logic [`DSP_LANES-1:0][`DSP_FFE_TAPS-1:0][`DSP_COEF_W-1:0] weight;
		logic [`DSP_LANES-1:0][`DSP_SHIFT_W-1:0]                  shift;
	} ffe_cfg_s;

	typedef struct packed {
		logic [`DSP_LANES-1:0][`DSP_EST_TAPS-1:0][`DSP_COEF_W-1:0] est;
		logic [`DSP_LANES-1:0][`DSP_THR_W-1:0]                    thr;
		logic [`DSP_LANES-1:0][`DSP_SHIFT_W-1:0]                  shift;
	} mlsd_cfg_s;

endpackage

/* design/lane_ffe.sv */
`timescale 1ns/1ns

`include "dsp_defines.svh"

module lane_ffe import dsp_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      win_vld_i,
	input  win_word_s win_i,
	input  ffe_cfg_s  ffe_cfg_i,
	output logic      est_vld_o,
	output est_word_s est_o
);

	localparam int PAST   = `DSP_FFE_TAPS - 1;
	localparam int PROD_W = `DSP_COEF_W + `DSP_CODE_W;
	localparam int ACC_W  = PROD_W + $clog2(`DSP_FFE_TAPS);

	localparam logic signed [ACC_W-1:0] EST_MAX = (1 << (`DSP_EST_W - 1)) - 1;
	localparam logic signed [ACC_W-1:0] EST_MIN = -EST_MAX - 1;

	est_word_s est_d;

	always_comb begin
		logic signed [ACC_W-1:0] acc;
		logic signed [ACC_W-1:0] shifted;
		est_d = '0;
		for (int k = 0; k < `DSP_LANES; k++) begin
			acc = '0;
			// tap t of lane k looks t samples back, which may land in the previous word.
			for (int t = 0; t < `DSP_FFE_TAPS; t++) begin
				acc = acc + $signed(ffe_cfg_i.weight[k][t]) * $signed(win_i.smp[k + PAST - t]);
			end
			shifted = acc >>> ffe_cfg_i.shift[k];
			if (shifted > EST_MAX) begin
				est_d.est[k] = EST_MAX[`DSP_EST_W-1:0];
			end else if (shifted < EST_MIN) begin
				est_d.est[k] = EST_MIN[`DSP_EST_W-1:0];
			end else begin
				est_d.est[k] = shifted[`DSP_EST_W-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			est_vld_o <= 1'b0;
		end else begin
			est_vld_o <= win_vld_i;
		end
	end

	always_ff @(posedge clk) begin
		if (win_vld_i) begin
			est_o <= est_d;
		end
	end

endmodule

/* design/mlsd_checker.sv */
`timescale 1ns/1ns

`include "dsp_defines.svh"

module mlsd_checker import dsp_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       bit_vld_i,
	input  bit_word_s  bits_i,
	input  code_word_s code_q_i,
	input  mlsd_cfg_s  mlsd_cfg_i,
	output logic       chk_vld_o,
	output bit_word_s  chk_o
);

	localparam int EXP_W  = `DSP_COEF_W + 2;
	localparam int DIST_W = EXP_W + 1;

	code_word_s code_d1;
	code_word_s code_d2;
	bit_word_s  chk_d;
	logic       last_q;
	logic       first_q;

	// raw codes run two stages behind code_history so they meet the slicer bits.
	always_ff @(posedge clk) begin
		code_d1 <= code_q_i;
		code_d2 <= code_d1;
	end

	always_comb begin
		logic                     prev;
		logic signed [EXP_W-1:0]  cur;
		logic signed [EXP_W-1:0]  post;
		logic signed [EXP_W-1:0]  exp_one;
		logic signed [EXP_W-1:0]  exp_zero;
		logic signed [DIST_W-1:0] dist_one;
		logic signed [DIST_W-1:0] dist_zero;
		prev  = last_q;
		chk_d = '0;
		for (int k = 0; k < `DSP_LANES; k++) begin
			cur  = $signed(mlsd_cfg_i.est[k][0]);
			post = $signed(mlsd_cfg_i.est[k][1]);
			if (!prev) begin
				post = -post;
			end
			exp_one  = (cur + post) >>> mlsd_cfg_i.shift[k];
			exp_zero = (post - cur) >>> mlsd_cfg_i.shift[k];
			dist_one  = $signed(code_d2.code[k]) - exp_one;
			dist_zero = $signed(code_d2.code[k]) - exp_zero;
			if (dist_one < 0) begin
				dist_one = -dist_one;
			end
			if (dist_zero < 0) begin
				dist_zero = -dist_zero;
			end
			// a tie goes to 1.
			chk_d.b[k] = dist_one <= dist_zero;
			// no decision exists before the first word, so lane 0 trusts the slicer.
			if (k == 0 && first_q) begin
				chk_d.b[k] = bits_i.b[k];
			end
			prev = chk_d.b[k];
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			chk_vld_o <= 1'b0;
			last_q    <= 1'b0;
			first_q   <= 1'b1;
		end else begin
			chk_vld_o <= bit_vld_i;
			if (bit_vld_i) begin
				last_q  <= chk_d.b[`DSP_LANES-1];
				first_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bit_vld_i) begin
			chk_o <= chk_d;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module dsp_backend_tb -f all.f -o dsp_sim || exit 1
out=$(./obj_dir/dsp_sim)
echo "$out"
echo "$out" | grep -qx "TESTBENCH PASSED" && exit 0 || exit 1
